// File: Bender.yml
package:
  name: bitbang

sources:
  - hdl/bitbang_pkg.sv
  - hdl/bitbang_rx.sv
  - hdl/cmd_exec.sv
  - hdl/rsp_fifo.sv
  - hdl/bitbang_top.sv
  - target: simulation
    files:
      - test/bitbang_tb.sv

// File: build.f
hdl/bitbang_pkg.sv
hdl/bitbang_rx.sv
hdl/cmd_exec.sv
hdl/rsp_fifo.sv
hdl/bitbang_top.sv
test/bitbang_tb.sv

// File: hdl/bitbang_pkg.sv
package bitbang_pkg;

  // control patterns seen on the falling edge of s_clk
  localparam int ctrl_w = 16;
  localparam logic [ctrl_w-1:0] on_pattern  = 16'hfab1;
  localparam logic [ctrl_w-1:0] off_pattern = 16'hfab0;

  // flops per input synchronizer
  localparam int sync_stages = 3;

  // command word and register bank
  localparam int word_w    = 32;
  localparam int reg_count = 16;
  localparam int reg_w     = 16;
  localparam int addr_w    = 4;

  // response queue
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // opcodes, anything else counts as unknown
  typedef enum logic [3:0] {
    op_nop          = 4'd0,
    op_write        = 4'd1,
    op_set_bits     = 4'd2,
    op_clr_bits     = 4'd3,
    op_read         = 4'd4,
    op_clear_status = 4'd5
  } bb_op_e;

  // overlay of the 32-bit command word, msb first
  typedef struct packed {
    bb_op_e              op;
    logic [7:0]          reserved;
    logic [addr_w-1:0]   addr;
    logic [reg_w-1:0]    data;
  } bb_cmd_t;

  // read response
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [reg_w-1:0]  data;
  } bb_rsp_t;

endpackage

// File: hdl/bitbang_rx.sv
`timescale 1ns/1ps

module bitbang_rx (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 s_clk,
  input  logic                 s_data,
  output bitbang_pkg::bb_cmd_t word,
  output logic                 word_valid,
  output logic                 active
);
  import bitbang_pkg::*;

  // sync chains, one flop past sync_stages for the edge compare
  logic [sync_stages:0] clk_sync;
  logic [sync_stages:0] data_sync;

  // edge strobes and the sampled host bit
  logic clk_rise;
  logic clk_fall;
  logic bit_in;

  // shifters
  logic [word_w-1:0] data_shift;
  logic [ctrl_w-1:0] ctrl_shift;

  // pattern compare
  logic on_match;
  logic off_match;
  logic on_match_q;
  logic commit;

  // input synchronizers
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      clk_sync  <= '0;
      data_sync <= '0;
    end else begin
      clk_sync  <= {clk_sync[sync_stages-1:0], s_clk};
      data_sync <= {data_sync[sync_stages-1:0], s_data};
    end
  end

  // oldest two samples of s_clk give the edge
  assign clk_rise = ~clk_sync[sync_stages] & clk_sync[sync_stages-1];
  assign clk_fall = clk_sync[sync_stages] & ~clk_sync[sync_stages-1];
  assign bit_in   = data_sync[sync_stages];

  // data bits on the rise, msb first
  always_ff @(posedge clk) begin
    if (clk_rise) begin
      data_shift <= {data_shift[word_w-2:0], bit_in};
    end
  end

  // control bits on the fall
  // same pin, other edge
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ctrl_shift <= '0;
    end else if (clk_fall) begin
      ctrl_shift <= {ctrl_shift[ctrl_w-2:0], bit_in};
    end
  end

  assign on_match  = (ctrl_shift == on_pattern);
  assign off_match = (ctrl_shift == off_pattern);

  // first cycle of a match only
  // the pattern stays put until the next falling edge
  assign commit = on_match & ~on_match_q;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      on_match_q <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      on_match_q <= on_match;
      word_valid <= commit;
    end
  end

  // word held until the next commit
  always_ff @(posedge clk) begin
    if (commit) begin
      word <= bb_cmd_t'(data_shift);
    end
  end

  // link state
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      active <= 1'b0;
    end else if (on_match) begin
      active <= 1'b1;
    end else if (off_match) begin
      active <= 1'b0;
    end
  end

endmodule

// File: hdl/bitbang_top.sv
`timescale 1ns/1ps

module bitbang_top (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 s_clk,
  input  logic                 s_data,
  input  logic                 rsp_ready,
  output bitbang_pkg::bb_rsp_t rsp,
  output logic                 rsp_valid,
  output logic                 active,
  output logic                 overflow,
  output logic                 bad_cmd
);
  import bitbang_pkg::*;

  // receiver to executor, no back-pressure
  bb_cmd_t word;
  logic    word_valid;

  // executor to response queue
  bb_rsp_t push_rsp;
  logic    push_valid;
  logic    push_ready;

  // serial front end
  bitbang_rx u_rx (
    .clk        (clk),
    .resetn     (resetn),
    .s_clk      (s_clk),
    .s_data     (s_data),
    .word       (word),
    .word_valid (word_valid),
    .active     (active)
  );

  // decode and register bank
  cmd_exec u_exec (
    .clk        (clk),
    .resetn     (resetn),
    .word       (word),
    .word_valid (word_valid),
    .push_ready (push_ready),
    .push_rsp   (push_rsp),
    .push_valid (push_valid),
    .overflow   (overflow),
    .bad_cmd    (bad_cmd)
  );

  // read responses out, stallable by rsp_ready
  rsp_fifo u_fifo (
    .clk        (clk),
    .resetn     (resetn),
    .push_rsp   (push_rsp),
    .push_valid (push_valid),
    .rsp_ready  (rsp_ready),
    .push_ready (push_ready),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid)
  );

endmodule

// File: hdl/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec (
  input  logic                 clk,
  input  logic                 resetn,
  input  bitbang_pkg::bb_cmd_t word,
  input  logic                 word_valid,
  input  logic                 push_ready,
  output bitbang_pkg::bb_rsp_t push_rsp,
  output logic                 push_valid,
  output logic                 overflow,
  output logic                 bad_cmd
);
  import bitbang_pkg::*;

  // register bank
  logic [reg_w-1:0] regs [reg_count];

  // current value at the addressed register
  logic [reg_w-1:0] cur;

  // decoded command class
  logic known_op;
  logic is_read;
  logic is_clear;

  assign cur = regs[word.addr];

  // opcode classification
  always_comb begin
    known_op = 1'b0;
    is_read  = 1'b0;
    is_clear = 1'b0;
    case (word.op)
      op_nop: begin
        known_op = 1'b1;
      end
      op_write: begin
        known_op = 1'b1;
      end
      op_set_bits: begin
        known_op = 1'b1;
      end
      op_clr_bits: begin
        known_op = 1'b1;
      end
      op_read: begin
        known_op = 1'b1;
        is_read  = 1'b1;
      end
      op_clear_status: begin
        known_op = 1'b1;
        is_clear = 1'b1;
      end
      default: begin
        known_op = 1'b0;
      end
    endcase
  end

  // register updates
  // nop, read, clear status and unknown codes leave the bank alone
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (word_valid) begin
      case (word.op)
        op_write: begin
          regs[word.addr] <= word.data;
        end
        op_set_bits: begin
          regs[word.addr] <= cur | word.data;
        end
        op_clr_bits: begin
          regs[word.addr] <= cur & ~word.data;
        end
        default: begin
          regs[word.addr] <= cur;
        end
      endcase
    end
  end

  // read offer, one cycle per read
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      push_valid <= 1'b0;
    end else begin
      push_valid <= word_valid & is_read;
    end
  end

  // response payload, sampled with the read
  always_ff @(posedge clk) begin
    if (word_valid && is_read) begin
      push_rsp.addr <= word.addr;
      push_rsp.data <= cur;
    end
  end

  // sticky status
  // a set in the same cycle as a clear wins
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      overflow <= 1'b0;
      bad_cmd  <= 1'b0;
    end else begin
      if (word_valid && is_clear) begin
        overflow <= 1'b0;
        bad_cmd  <= 1'b0;
      end
      // fifo refused the offer, response lost
      if (push_valid && !push_ready) begin
        overflow <= 1'b1;
      end
      if (word_valid && !known_op) begin
        bad_cmd <= 1'b1;
      end
    end
  end

endmodule

// File: hdl/rsp_fifo.sv
`timescale 1ns/1ps

module rsp_fifo (
  input  logic                 clk,
  input  logic                 resetn,
  input  bitbang_pkg::bb_rsp_t push_rsp,
  input  logic                 push_valid,
  input  logic                 rsp_ready,
  output logic                 push_ready,
  output bitbang_pkg::bb_rsp_t rsp,
  output logic                 rsp_valid
);
  import bitbang_pkg::*;

  // storage
  bb_rsp_t mem [fifo_depth];

  // pointers and fill level
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;

  // handshakes
  logic full;
  logic push;
  logic pop;

  // wrap at depth, not at the pointer width
  function automatic logic [fifo_ptr_w-1:0] next_ptr(input logic [fifo_ptr_w-1:0] ptr);
    if (ptr == fifo_ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == fifo_cnt_w'(fifo_depth));
  assign rsp_valid = (count != '0);
  assign pop       = rsp_valid & rsp_ready;
  // full but draining this cycle still takes a push
  assign push_ready = ~full | pop;
  assign push       = push_valid & push_ready;

  // head of queue, registered storage so no bypass
  assign rsp = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_rsp;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // level moves only when one side is idle
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: test/bitbang_tb.sv
`timescale 1ns/1ps

module bitbang_tb;
  import bitbang_pkg::*;

  // frame counts per behavior and the watchdog limit
  localparam int n_mix         = 48;
  localparam int total_frames  = 2 * reg_count + n_mix + 2 + 7 + 4;
  localparam int period_cycles = 12;
  localparam int margin_cycles = 4000;
  localparam longint limit_ns  =
    (longint'(total_frames) * 33 * period_cycles + margin_cycles) * 10;

  // DUT pins
  logic    clk;
  logic    resetn;
  logic    s_clk;
  logic    s_data;
  logic    rsp_ready;
  bb_rsp_t rsp;
  logic    rsp_valid;
  logic    active;
  logic    overflow;
  logic    bad_cmd;

  // lfsr state and rsp_ready mode
  // mode 0 holds low, 1 holds high, 2 draws each cycle
  logic [31:0] lfsr;
  logic [1:0]  ready_mode;
  logic [31:0] ready_draw;

  // register model and expected responses
  logic [reg_w-1:0] model_regs [reg_count];
  bb_rsp_t          exp_q [$];
  bb_rsp_t          exp_rsp;
  int               errors;
  int               rsp_count;
  int               count_before;

  // stimulus scratch
  logic [31:0]       sel;
  logic [addr_w-1:0] a;
  logic [reg_w-1:0]  d;

  bitbang_top UUT (
    .clk       (clk),
    .resetn    (resetn),
    .s_clk     (s_clk),
    .s_data    (s_data),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .active    (active),
    .overflow  (overflow),
    .bad_cmd   (bad_cmd)
  );

  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] pack_cmd(input logic [3:0] op, input logic [addr_w-1:0] addr,
                                           input logic [reg_w-1:0] data);
    return {op, 8'h00, addr, data};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // data bit before the rise and control bit before the fall
  // each level lasts 6 cycles
  task automatic send_period(input logic dbit, input logic cbit);
    s_data = dbit;
    wait_cycles(3);
    s_clk = 1'b1;
    wait_cycles(3);
    s_data = cbit;
    wait_cycles(3);
    s_clk = 1'b0;
    wait_cycles(3);
  endtask

  task automatic send_frame(input logic [31:0] word, input logic [15:0] pattern);
    for (int i = 0; i < 32; i++) begin
      send_period(word[31-i], (i < 16) ? 1'b0 : pattern[31-i]);
    end
    // s_clk low 8 cycles after the last fall
    wait_cycles(5);
    // extra period with control 0 breaks the match
    send_period(1'b0, 1'b0);
  endtask

  // model update then the frame itself
  task automatic send_cmd(input logic [3:0] op, input logic [addr_w-1:0] addr,
                          input logic [reg_w-1:0] data, input bit keep);
    bb_rsp_t e;
    e.addr = addr;
    e.data = model_regs[addr];
    case (op)
      op_write:    model_regs[addr] = data;
      op_set_bits: model_regs[addr] = model_regs[addr] | data;
      op_clr_bits: model_regs[addr] = model_regs[addr] & ~data;
      op_read: begin
        if (keep) begin
          exp_q.push_back(e);
        end
      end
      default: ;
    endcase
    send_frame(pack_cmd(op, addr, data), on_pattern);
  endtask

  // until every expected response has left
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    wait_cycles(4);
  endtask

  // ready drawn on the edge and driven 1 ns later
  always @(posedge clk) begin
    if (ready_mode == 2'd2) begin
      ready_draw = rand_bits(1);
    end else begin
      ready_draw = {31'd0, ready_mode[0]};
    end
    #1;
    rsp_ready = ready_draw[0];
  end

  // transfer seen on the falling edge before the rise that takes it
  always @(negedge clk) begin
    if (resetn && rsp_valid && rsp_ready) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected response addr %h data %h with no read outstanding at %0t",
                 rsp.addr, rsp.data, $time);
      end else begin
        exp_rsp = exp_q.pop_front();
        compare("rsp.addr", rsp.addr, exp_rsp.addr);
        compare("rsp.data", rsp.data, exp_rsp.data);
      end
    end
  end

  initial begin
    #(limit_ns);
    $display("timeout after %0d ns, the command stream did not complete", limit_ns);
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    resetn     = 1'b0;
    s_clk      = 1'b0;
    s_data     = 1'b0;
    rsp_ready  = 1'b0;
    ready_mode = 2'd0;
    lfsr       = 32'hd464_230e;
    errors     = 0;
    rsp_count  = 0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    resetn = 1'b1;
    wait_cycles(2);
    compare("active", active, 1'b0);
    compare("overflow", overflow, 1'b0);
    compare("bad_cmd", bad_cmd, 1'b0);
    compare("rsp_valid", rsp_valid, 1'b0);

    // write every address and read all back in order
    ready_mode = 2'd1;
    for (int i = 0; i < reg_count; i++) begin
      send_cmd(op_write, addr_w'(i), reg_w'(rand_bits(reg_w)), 1'b1);
    end
    for (int i = 0; i < reg_count; i++) begin
      send_cmd(op_read, addr_w'(i), '0, 1'b1);
    end
    wait_drain();
    compare("active", active, 1'b1);

    // random mix under a random ready
    ready_mode = 2'd2;
    for (int n = 0; n < n_mix; n++) begin
      sel = rand_bits(2);
      a   = addr_w'(rand_bits(addr_w));
      d   = reg_w'(rand_bits(reg_w));
      case (sel[1:0])
        2'd0:    send_cmd(op_write, a, d, 1'b1);
        2'd1:    send_cmd(op_set_bits, a, d, 1'b1);
        2'd2:    send_cmd(op_clr_bits, a, d, 1'b1);
        default: send_cmd(op_read, a, '0, 1'b1);
      endcase
    end
    wait_drain();
    ready_mode = 2'd1;
    compare("overflow", overflow, 1'b0);

    // off pattern drops the link and the word never lands
    a = addr_w'(rand_bits(addr_w));
    send_frame(pack_cmd(op_write, a, ~model_regs[a]), off_pattern);
    compare("active", active, 1'b0);
    send_cmd(op_read, a, '0, 1'b1);
    compare("active", active, 1'b1);
    wait_drain();

    // stalled output keeps only fifo_depth reads
    ready_mode = 2'd0;
    wait_cycles(2);
    count_before = rsp_count;
    for (int n = 0; n < 6; n++) begin
      send_cmd(op_read, addr_w'(n), '0, n < fifo_depth);
    end
    compare("overflow", overflow, 1'b1);
    // oldest read waits at the head
    compare("rsp_valid", rsp_valid, 1'b1);
    compare("rsp.addr", rsp.addr, exp_q[0].addr);
    compare("rsp.data", rsp.data, exp_q[0].data);
    ready_mode = 2'd1;
    wait_drain();
    compare("rsp_count", rsp_count - count_before, fifo_depth);
    send_cmd(op_clear_status, '0, '0, 1'b1);
    compare("overflow", overflow, 1'b0);

    // unknown opcode leaves the register alone
    a = addr_w'(rand_bits(addr_w));
    d = reg_w'(rand_bits(reg_w));
    send_cmd(op_write, a, d, 1'b1);
    send_frame(pack_cmd(4'hf, a, ~d), on_pattern);
    compare("bad_cmd", bad_cmd, 1'b1);
    send_cmd(op_read, a, '0, 1'b1);
    wait_drain();
    send_cmd(op_clear_status, '0, '0, 1'b1);
    compare("bad_cmd", bad_cmd, 1'b0);

    $display("errors %0d, responses checked %0d", errors, rsp_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
